//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_spindle
FLAGS ?= --timing
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
PASS_MSG := Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILE_LIST)) sim/spindle_model.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# status comes from the pass line in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

//--- common/spindle_pkg.sv
`default_nettype none

package spindle_pkg;

	// signed Q16.16 fixed point
	localparam int FRAC_BITS = 16;
	localparam int DT_SHIFT = 8;

	typedef logic signed [31:0] fix_t;

	typedef enum logic [1:0] {
		PH_BAG1  = 2'd0,
		PH_BAG2  = 2'd1,
		PH_CHAIN = 2'd2
	} phase_t;

	// x0 activation, x1 length, x2 velocity
	typedef struct packed {
		fix_t x0;
		fix_t x1;
		fix_t x2;
	} fiber_state_t;

	typedef struct packed {
		fix_t dx0;
		fix_t dx1;
		fix_t dx2;
	} fiber_deriv_t;

	typedef struct packed {
		fix_t gamma_dyn;
		fix_t gamma_sta;
		fix_t lce;
	} spindle_drive_t;

	typedef struct packed {
		fix_t bag1;
		fix_t bag2;
		fix_t chain;
	} fiber_damping_t;

	typedef struct packed {
		fix_t ia;
		fix_t ii;
	} afferent_rates_t;

	localparam fix_t FIX_ONE = 32'sd65536;

	// per-fiber tables, ordered bag1, bag2, chain
	localparam fix_t RATE_K [0:2] = '{32'sd439812, 32'sd319685, 32'sd0};
	localparam fix_t KSR_PLUS_KPR [0:2] = '{32'sd693214, 32'sd696464, 32'sd696464};
	localparam fix_t FORCE_GAIN [0:2] = '{32'sd1894, 32'sd4168, 32'sd6252};
	localparam fix_t IA_GAIN [0:2] = '{32'sd13107200, 32'sd6553600, 32'sd6553600};

	localparam fix_t KSR        = 32'sd685828;   // 10.4649
	localparam fix_t INV_MASS   = 32'sd3276800;  // 50.0, mass scaled up for dt
	localparam fix_t REST_FORCE = 32'sd21820;    // ksr*lsr0 - kpr*lpr0
	localparam fix_t LSR0       = 32'sd2621;     // 0.04
	localparam fix_t II_GAIN    = 32'sd4751360;  // 72.5
	localparam fix_t II_C0      = 32'sd45875;    // 0.7
	localparam fix_t II_C3      = 32'sd1035;     // 0.01579
	localparam fix_t II_C6      = 32'sd62915;    // 0.96
	localparam fix_t OCCLUSION  = 32'sd10224;    // 0.156
	localparam fix_t RATE_MAX   = 32'sd65536000; // 1000 pps
	localparam fix_t X1_INIT    = 32'sd62777;    // 0.9579

	// full product, rescaled and truncated back to one word
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic signed [63:0] prod;
		logic signed [63:0] shifted;
		prod = 64'(a) * 64'(b);
		shifted = prod >>> FRAC_BITS;
		return shifted[31:0];
	endfunction

endpackage

`default_nettype wire

//--- fiber/fiber_derivatives.sv
`timescale 1ns/1ps
`default_nettype none

module fiber_derivatives (
	input  spindle_pkg::phase_t         phase,
	input  spindle_pkg::spindle_drive_t drive,
	input  spindle_pkg::fiber_damping_t damping,
	input  spindle_pkg::fiber_state_t   cur_state,
	output spindle_pkg::fiber_deriv_t   deriv
);
	import spindle_pkg::*;

	fix_t gamma;
	fix_t damp;
	fix_t act;
	fix_t xe;
	fix_t act_err;
	fix_t ksr_term;
	fix_t spring_term;
	fix_t visc_term;
	fix_t force_term;
	fix_t net_force;

	// bag1 follows dynamic gamma, bag2 and chain the static one
	always_comb begin
		case (phase)
			PH_BAG1: begin
				gamma = drive.gamma_dyn;
				damp = damping.bag1;
			end
			PH_BAG2: begin
				gamma = drive.gamma_sta;
				damp = damping.bag2;
			end
			default: begin
				gamma = drive.gamma_sta;
				damp = damping.chain;
			end
		endcase
	end

	// activation saturates to [0, 1]
	always_comb begin
		if (gamma < 0) begin
			act = '0;
		end else if (gamma > FIX_ONE) begin
			act = FIX_ONE;
		end else begin
			act = gamma;
		end
	end

	// chain has no activation dynamics, it uses the activation directly
	assign xe = (phase == PH_CHAIN) ? act : cur_state.x0;
	assign act_err = act - cur_state.x0;

	always_comb begin
		ksr_term = fix_mul(KSR, drive.lce);
		spring_term = fix_mul(KSR_PLUS_KPR[phase], cur_state.x1);
		visc_term = fix_mul(damp, fix_mul(xe, cur_state.x2));
		force_term = fix_mul(FORCE_GAIN[phase], xe);
		net_force = ksr_term - spring_term - visc_term - force_term - REST_FORCE;
	end

	// rate table entry is zero for chain
	assign deriv.dx0 = fix_mul(RATE_K[phase], act_err);
	assign deriv.dx1 = cur_state.x2;
	assign deriv.dx2 = fix_mul(INV_MASS, net_force);

endmodule

`default_nettype wire

//--- fiber/fiber_state_bank.sv
`timescale 1ns/1ps
`default_nettype none

module fiber_state_bank (
	input  wire                       clk,
	input  wire                       reset,
	input  spindle_pkg::phase_t       phase,
	input  spindle_pkg::fiber_deriv_t deriv,
	output spindle_pkg::fiber_state_t cur_state,
	output spindle_pkg::fix_t         new_length
);
	import spindle_pkg::*;

	// one state word set per fiber, indexed by phase
	fiber_state_t fiber_q [0:2];
	fiber_state_t next_state;

	// forward euler with dt = 2^-DT_SHIFT
	function automatic fix_t euler_step(input fix_t x, input fix_t dx);
		fix_t scaled;
		scaled = dx >>> DT_SHIFT;
		return x + scaled;
	endfunction

	always_comb begin
		case (phase)
			PH_BAG1: begin
				cur_state = fiber_q[0];
			end
			PH_BAG2: begin
				cur_state = fiber_q[1];
			end
			default: begin
				cur_state = fiber_q[2];
			end
		endcase
	end

	always_comb begin
		next_state.x0 = euler_step(cur_state.x0, deriv.dx0);
		next_state.x1 = euler_step(cur_state.x1, deriv.dx1);
		next_state.x2 = euler_step(cur_state.x2, deriv.dx2);
	end

	// updated length feeds the afferent encoder in the same cycle
	assign new_length = next_state.x1;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 3; i++) begin
				fiber_q[i] <= '{x0: '0, x1: X1_INIT, x2: '0};
			end
		end else begin
			case (phase)
				PH_BAG1: begin
					fiber_q[0] <= next_state;
				end
				PH_BAG2: begin
					fiber_q[1] <= next_state;
				end
				default: begin
					fiber_q[2] <= next_state;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/afferent_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module afferent_encoder (
	input  wire                          clk,
	input  wire                          reset,
	input  spindle_pkg::phase_t          phase,
	input  spindle_pkg::spindle_drive_t  drive,
	input  spindle_pkg::fix_t            new_length,
	output spindle_pkg::afferent_rates_t rates
);
	import spindle_pkg::*;

	fix_t stretch;
	fix_t ia_raw;
	fix_t ii_raw;
	fix_t ia_fiber;
	fix_t ii_fiber;
	fix_t ia_bag1_q;
	fix_t ia_bag2_q;
	fix_t ii_bag2_q;
	fix_t ia_sum;
	fix_t ia_larger;
	fix_t ia_smaller;
	afferent_rates_t muscle;

	// firing rate limited to [0, RATE_MAX]
	function automatic fix_t clamp_rate(input fix_t v);
		if (v < 0) begin
			return '0;
		end else if (v > RATE_MAX) begin
			return RATE_MAX;
		end
		return v;
	endfunction

	// sensory region stretch of the current fiber
	assign stretch = drive.lce - new_length - LSR0;

	always_comb begin
		ia_raw = fix_mul(IA_GAIN[phase], stretch);
		ii_raw = fix_mul(II_GAIN, fix_mul(II_C0, stretch)
			+ fix_mul(II_C3, drive.lce - stretch - II_C6));
		ia_fiber = clamp_rate(ia_raw);
		ii_fiber = clamp_rate(ii_raw);
	end

	// bag1 occludes the bag2 plus chain contribution
	always_comb begin
		ia_sum = ia_bag2_q + ia_fiber;
		if (ia_bag1_q >= ia_sum) begin
			ia_larger = ia_bag1_q;
			ia_smaller = ia_sum;
		end else begin
			ia_larger = ia_sum;
			ia_smaller = ia_bag1_q;
		end
		muscle.ia = ia_larger + fix_mul(OCCLUSION, ia_smaller);
		muscle.ii = ii_bag2_q + ii_fiber;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ia_bag1_q <= '0;
			ia_bag2_q <= '0;
			ii_bag2_q <= '0;
			rates <= '0;
		end else begin
			case (phase)
				PH_BAG1: begin
					ia_bag1_q <= ia_fiber;
				end
				PH_BAG2: begin
					ia_bag2_q <= ia_fiber;
					ii_bag2_q <= ii_fiber;
				end
				default: begin
					rates <= muscle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/phase_control.sv
`timescale 1ns/1ps
`default_nettype none

module phase_control (
	input  wire                 clk,
	input  wire                 reset,
	output spindle_pkg::phase_t phase
);
	import spindle_pkg::*;

	// bag1 -> bag2 -> chain, one step per clock
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= PH_BAG1;
		end else begin
			case (phase)
				PH_BAG1: begin
					phase <= PH_BAG2;
				end
				PH_BAG2: begin
					phase <= PH_CHAIN;
				end
				default: begin
					phase <= PH_BAG1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/spindle_top.sv
`timescale 1ns/1ps
`default_nettype none

module spindle_top (
	input  wire                          clk,
	input  wire                          reset,
	input  spindle_pkg::spindle_drive_t  drive,
	input  spindle_pkg::fiber_damping_t  damping,
	output spindle_pkg::afferent_rates_t rates
);
	import spindle_pkg::*;

	phase_t       phase;
	fiber_state_t cur_state;
	fiber_deriv_t deriv;
	fix_t         new_length;

	phase_control u_phase_control (
		.clk   (clk),
		.reset (reset),
		.phase (phase)
	);

	// one fiber per cycle through the shared derivative path
	fiber_state_bank u_fiber_state_bank (
		.clk        (clk),
		.reset      (reset),
		.phase      (phase),
		.deriv      (deriv),
		.cur_state  (cur_state),
		.new_length (new_length)
	);

	fiber_derivatives u_fiber_derivatives (
		.phase     (phase),
		.drive     (drive),
		.damping   (damping),
		.cur_state (cur_state),
		.deriv     (deriv)
	);

	afferent_encoder u_afferent_encoder (
		.clk        (clk),
		.reset      (reset),
		.phase      (phase),
		.drive      (drive),
		.new_length (new_length),
		.rates      (rates)
	);

endmodule

`default_nettype wire

//--- list.f
+incdir+sim
common/spindle_pkg.sv
hdl/phase_control.sv
fiber/fiber_state_bank.sv
fiber/fiber_derivatives.sv
hdl/afferent_encoder.sv
hdl/spindle_top.sv
sim/tb_spindle.sv

//--- sim/spindle_model.svh
`ifndef SPINDLE_MODEL_SVH
`define SPINDLE_MODEL_SVH

// expected spindle state between two rising edges
typedef struct packed {
	phase_t             phase;
	fiber_state_t [2:0] fiber;
	fix_t               ia_bag1;
	fix_t               ia_bag2;
	fix_t               ii_bag2;
	afferent_rates_t    rates;
} model_t;

function automatic longint wide(input fix_t v);
	return longint'(v);
endfunction

// back to one Q16.16 word, two's complement wrap
function automatic longint wrap(input longint v);
	return wide(fix_t'(v));
endfunction

function automatic longint qmul(input longint a, input longint b);
	longint p;
	p = (a * b) >>> FRAC_BITS;
	return wrap(p);
endfunction

function automatic longint limit_rate(input longint v);
	if (v < 0) begin
		return 0;
	end
	if (v > wide(RATE_MAX)) begin
		return wide(RATE_MAX);
	end
	return v;
endfunction

function automatic model_t model_reset();
	model_t m;
	m = '0;
	for (int i = 0; i < 3; i++) begin
		m.fiber[i].x1 = X1_INIT;
	end
	m.phase = PH_BAG1;
	return m;
endfunction

// one rising edge of the whole spindle, fiber[0] is bag1
function automatic model_t model_step(input model_t m, input spindle_drive_t d,
		input fiber_damping_t dmp);
	model_t n;
	fiber_state_t s;
	longint lce, gam, act, dmp_v, xe;
	longint dx0, dx2, net, x1_new;
	longint stretch, ia, ii, sum, bag1;
	n = m;
	s = m.fiber[m.phase];
	lce = wide(d.lce);
	gam = (m.phase == PH_BAG1) ? wide(d.gamma_dyn) : wide(d.gamma_sta);
	act = (gam < 0) ? 0 : ((gam > wide(FIX_ONE)) ? wide(FIX_ONE) : gam);
	dmp_v = (m.phase == PH_BAG1) ? wide(dmp.bag1)
		: ((m.phase == PH_BAG2) ? wide(dmp.bag2) : wide(dmp.chain));
	// chain has no activation state of its own
	xe = (m.phase == PH_CHAIN) ? act : wide(s.x0);
	dx0 = (m.phase == PH_CHAIN) ? 0 : qmul(wide(RATE_K[m.phase]), wrap(act - wide(s.x0)));
	net = wrap(qmul(wide(KSR), lce) - qmul(wide(KSR_PLUS_KPR[m.phase]), wide(s.x1))
		- qmul(dmp_v, qmul(xe, wide(s.x2))) - qmul(wide(FORCE_GAIN[m.phase]), xe)
		- wide(REST_FORCE));
	dx2 = qmul(wide(INV_MASS), net);
	x1_new = wrap(wide(s.x1) + (wide(s.x2) >>> DT_SHIFT));
	n.fiber[m.phase].x0 = fix_t'(wide(s.x0) + (dx0 >>> DT_SHIFT));
	n.fiber[m.phase].x1 = fix_t'(x1_new);
	n.fiber[m.phase].x2 = fix_t'(wide(s.x2) + (dx2 >>> DT_SHIFT));
	stretch = wrap(lce - x1_new - wide(LSR0));
	ia = limit_rate(qmul(wide(IA_GAIN[m.phase]), stretch));
	ii = limit_rate(qmul(wide(II_GAIN), wrap(qmul(wide(II_C0), stretch)
		+ qmul(wide(II_C3), wrap(lce - stretch - wide(II_C6))))));
	case (m.phase)
		PH_BAG1: begin
			n.ia_bag1 = fix_t'(ia);
			n.phase = PH_BAG2;
		end
		PH_BAG2: begin
			n.ia_bag2 = fix_t'(ia);
			n.ii_bag2 = fix_t'(ii);
			n.phase = PH_CHAIN;
		end
		default: begin
			sum = wide(m.ia_bag2) + ia;
			bag1 = wide(m.ia_bag1);
			n.rates.ia = fix_t'((bag1 >= sum) ? bag1 + qmul(wide(OCCLUSION), sum)
				: sum + qmul(wide(OCCLUSION), bag1));
			n.rates.ii = fix_t'(wide(m.ii_bag2) + ii);
			n.phase = PH_BAG1;
		end
	endcase
	return n;
endfunction

`endif

//--- sim/tb_spindle.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spindle;
	import spindle_pkg::*;

	localparam int MAX_CYCLES = 5000;
	localparam int FIRST_UPDATE_LIMIT = 20;
	localparam fix_t LCE_NOMINAL = 32'sd78643;  // 1.2
	localparam fix_t LCE_SHORT = 32'sd16384;    // 0.25
	localparam fix_t LCE_LONG = 32'sd2621440;   // 40.0
	localparam fix_t LCE_RANDOM = 32'sd72090;   // 1.1
	localparam fix_t DAMP_INIT = 32'sd131072;   // 2.0

	logic clk;
	logic reset;
	spindle_drive_t drive;
	fiber_damping_t damping;
	afferent_rates_t rates;
	int seed;

	`include "spindle_model.svh"

	spindle_top uut (
		.clk     (clk),
		.reset   (reset),
		.drive   (drive),
		.damping (damping),
		.rates   (rates)
	);

	always #4 clk = ~clk;

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			$display("CHECK FAILED at %0t ns: %s expected %0d, actual %0d",
				$time, name, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic run_cycles(input int count);
		repeat (count) @(negedge clk);
	endtask

	// model follows every rising edge, outputs compared just after it
	initial begin : compare
		model_t model;
		model = model_reset();
		forever begin
			@(posedge clk);
			if (reset) begin
				model = model_reset();
			end else begin
				model = model_step(model, drive, damping);
			end
			#1;
			check_value("rates.ia", model.rates.ia, rates.ia);
			check_value("rates.ii", model.rates.ii, rates.ii);
		end
	end

	initial begin : watchdog
		for (int i = 0; i < MAX_CYCLES; i++) begin
			@(posedge clk);
		end
		$display("simulation did not finish within %0d cycles", MAX_CYCLES);
		$display("Test failed");
		$fatal(1);
	end

	initial begin : stimulus
		int edges;
		int high_ia;
		fix_t lce_step;
		clk = 1'b0;
		reset = 1'b1;
		seed = 32;
		drive = '{gamma_dyn: '0, gamma_sta: '0, lce: LCE_NOMINAL};
		damping = '{bag1: DAMP_INIT, bag2: DAMP_INIT, chain: DAMP_INIT};
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// first output update, bag1 then bag2 then chain
		edges = 0;
		while (rates.ia == 0 && edges < FIRST_UPDATE_LIMIT) begin
			@(posedge clk);
			#1;
			edges++;
		end
		if (rates.ia == 0) begin
			$display("timeout waiting for the first output update after reset");
			$display("Test failed");
			$fatal(1);
		end
		check_value("first update edge", 3, edges);

		// constant drive
		run_cycles(600);

		// short muscle, no stretch on any fiber
		drive.lce = LCE_SHORT;
		run_cycles(12);
		check_value("rates.ia short", 0, rates.ia);
		check_value("rates.ii short", 0, rates.ii);

		// long muscle, every fiber saturates
		high_ia = 2 * RATE_MAX + int'((longint'(OCCLUSION) * longint'(RATE_MAX)) >>> FRAC_BITS);
		drive.lce = LCE_LONG;
		run_cycles(12);
		check_value("rates.ia long", high_ia, rates.ia);
		check_value("rates.ii long", 2 * RATE_MAX, rates.ii);

		// reset in the middle of a run
		reset = 1'b1;
		drive.lce = LCE_RANDOM;
		#1;
		check_value("rates.ia in reset", 0, rates.ia);
		check_value("rates.ii in reset", 0, rates.ii);
		run_cycles(2);
		reset = 1'b0;
		run_cycles(60);

		// gamma steps, both sides of the activation clamp
		for (int i = 0; i < 25; i++) begin
			drive.gamma_dyn = $random(seed) % (3 * 65536);
			drive.gamma_sta = $random(seed) % (3 * 65536);
			run_cycles(8);
		end

		// damping changes and lce ramps, bag1 and bag2+chain trade places
		for (int i = 0; i < 30; i++) begin
			damping.bag1 = {$random(seed)} % (4 * 65536);
			damping.bag2 = {$random(seed)} % (4 * 65536);
			damping.chain = {$random(seed)} % (4 * 65536);
			drive.gamma_dyn = {$random(seed)} % 65536;
			lce_step = $random(seed) % 600;
			for (int j = 0; j < 10; j++) begin
				drive.lce = drive.lce + lce_step;
				@(negedge clk);
			end
		end

		@(negedge clk);
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
